/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = mipsCoreTb
FILELIST = sources.f

.PHONY: sim clean

# Build and run, pass only if the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* dv/mipsCoreTb.sv */
`default_nettype none

module mipsCoreTb;
	timeunit 1ns;
	timeprecision 100ps;
	import mipsPkg::*;

	localparam int ProgLen = 201;	// 200 random words plus HALT
	localparam int TimeoutCycles = 4 * ProgLen + 50;
	localparam logic [5:0] RFuncts [8] = '{AluAdd, AluAddu, AluSub, AluAnd,
		AluOr, AluXor, AluSlt, AluSltu};
	localparam logic [5:0] IOps [8] = '{OpAddi, OpAddiu, OpSlti, OpSltiu,
		OpAndi, OpOri, OpXori, OpLui};

	logic clk = 1'b0;
	logic rst, instrValid, creditReturn, wbValid, halted;
	instrWord instr;
	logic [RegAddrWidth-1:0] wbReg;
	logic [31:0] wbData;

	instrWord prog [ProgLen];
	logic [31:0] rng;
	logic [31:0] modelRegs [RegCount];
	logic [31:0] modelMem [MemWords];
	logic [RegAddrWidth-1:0] expReg [$];
	logic [31:0] expData [$];
	int credits = QueueDepth;
	int sent = 0;
	int returned = 0;
	int cycles = 0;
	int quietCycles = 0;
	bit haltSeen = 1'b0;

	mipsCore mipsCore_i (.*);

	initial
	begin
		forever #50 clk = ~clk;
	end

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("Test FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic instrWord encodeR(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {OpRType, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic instrWord encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Program generator
	//////////////////////////////////////////////////////////////////////
	task automatic buildProgram();
		logic [31:0] rnd;
		logic [15:0] imm, memOff;
		logic [4:0] rs, rt, rd, lastDest;
		int kind;
		bit loadNext;
		lastDest = 5'd1;
		loadNext = 1'b0;
		memOff = '0;
		for (int k = 0; k < ProgLen; k++)
		begin
			rng = xorshift(rng);
			rnd = rng;
			rng = xorshift(rng);
			imm = rng[15:0];
			rs = 5'(rnd[7:0] % 7 + 1);
			rt = 5'(rnd[15:8] % 7 + 1);
			rd = 5'(rnd[23:16] % 7 + 1);
			kind = int'(rnd[31:24] % 18);
			if (k % 4 == 1)
				rs = lastDest;	// Forced back-to-back dependency
			if (k < 7)
			begin
				prog[k] = encodeI(OpAddiu, 5'd0, 5'(k + 1), imm);	// Seed r1..r7
				lastDest = 5'(k + 1);
			end
			else if (k == ProgLen - 1)
				prog[k] = encodeI(OpHalt, 5'd0, 5'd0, 16'd0);
			else if (loadNext)
			begin
				prog[k] = encodeI(OpLw, 5'd0, rt, memOff);	// Reads the word just stored
				loadNext = 1'b0;
				lastDest = rt;
			end
			else if (kind < 8)
			begin
				prog[k] = encodeR(RFuncts[kind], rs, rt, rd);
				lastDest = rd;
			end
			else if (kind < 16)
			begin
				prog[k] = encodeI(IOps[kind - 8], rs, rt, imm);
				lastDest = rt;
			end
			else
			begin
				memOff = {10'd0, imm[3:0], 2'b00};	// Word offset inside data memory
				prog[k] = encodeI((kind == 16) ? OpLw : OpSw, 5'd0, rt, memOff);
				loadNext = (kind == 17);
				if (kind == 16)
					lastDest = rt;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model, run as each word is sent
	//////////////////////////////////////////////////////////////////////
	task automatic applyModel(input instrWord w);
		logic [31:0] a, b, sImm, zImm, addr, res;
		logic [4:0] dest;
		bit writes;
		a = modelRegs[w.i.rs];
		b = modelRegs[w.i.rt];
		sImm = {{16{w.i.imm[15]}}, w.i.imm};
		zImm = {16'b0, w.i.imm};
		addr = a + sImm;
		dest = w.i.rt;
		writes = 1'b1;
		res = '0;
		case (w.i.op)
			OpRType:
			begin
				dest = w.r.rd;
				case (w.r.funct)
					AluAdd, AluAddu: res = a + b;
					AluSub: res = a - b;
					AluAnd: res = a & b;
					AluOr: res = a | b;
					AluXor: res = a ^ b;
					AluSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: res = (a < b) ? 32'd1 : 32'd0;
				endcase
			end
			OpAddi, OpAddiu: res = a + sImm;
			OpSlti: res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
			OpSltiu: res = (a < sImm) ? 32'd1 : 32'd0;
			OpAndi: res = a & zImm;
			OpOri: res = a | zImm;
			OpXori: res = a ^ zImm;
			OpLui: res = {w.i.imm, 16'b0};
			OpLw: res = modelMem[addr[5:2]];
			OpSw:
			begin
				modelMem[addr[5:2]] = b;
				writes = 1'b0;
			end
			default: writes = 1'b0;	// HALT
		endcase
		if (writes && dest != 5'd0)
		begin
			modelRegs[dest] = res;
			expReg.push_back(dest);
			expData.push_back(res);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sender and checks, all on the falling edge
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		logic [RegAddrWidth-1:0] wantReg;
		logic [31:0] wantData;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		rng = 32'h3623;
		for (int r = 0; r < RegCount; r++)
			modelRegs[r] = '0;
		for (int m = 0; m < MemWords; m++)
			modelMem[m] = '0;
		buildProgram();
		repeat (3) @(negedge clk);
		rst = 1'b0;
		while (quietCycles < 4)
		begin
			@(negedge clk);
			cycles++;
			assert (cycles <= TimeoutCycles)
			else stopOnError($sformatf("timeout: core did not halt within %0d cycles",
				TimeoutCycles));
			if (creditReturn)
			begin
				returned++;
				credits++;
			end
			assert (returned <= sent)
			else stopOnError("more credits returned than words sent");
			if (wbValid)
			begin
				assert (!haltSeen) else stopOnError("writeback after the core halted");
				assert (expReg.size() > 0) else stopOnError("writeback with none expected");
				wantReg = expReg.pop_front();
				wantData = expData.pop_front();
				assert (wbReg == wantReg && wbData == wantData)
				else stopOnError($sformatf("mismatch at %0t: wrote r%0d = %h, expected r%0d = %h",
					$time, wbReg, wbData, wantReg, wantData));
			end
			if (haltSeen)
				quietCycles++;
			else if (halted)
			begin
				assert (sent == ProgLen) else stopOnError("halted rose before HALT was sent");
				assert (expReg.size() == 0)
				else stopOnError($sformatf("halted with %0d writes missing", expReg.size()));
				haltSeen = 1'b1;
			end
			instrValid = 1'b0;
			if (sent < ProgLen && credits > 0)
			begin
				instr = prog[sent];
				instrValid = 1'b1;
				applyModel(prog[sent]);
				sent++;
				credits--;
			end
		end
		if (credits == QueueDepth && returned == sent)
		begin
			$display("Test OK");
			$finish;
		end
		else
			stopOnError($sformatf("only %0d of %0d credits came back", returned, sent));
	end

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
`default_nettype none

module controlUnit (
	input  mipsPkg::instrWord instr,
	output logic memToReg,	// Writeback from load data
	output logic memWrite,
	output logic aluSrc,	// Second operand is the immediate
	output logic regDst,	// 1 writes rd, 0 writes rt
	output logic regWrite,
	output logic signExtend,
	output logic [5:0] aluControl,
	output logic halt
);
	import mipsPkg::*;

	always_comb
	begin
		// NOP unless the opcode says otherwise
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrc = 1'b0;
		regDst = 1'b0;
		regWrite = 1'b0;
		signExtend = 1'b0;
		aluControl = '0;
		halt = 1'b0;

		case (instr.i.op)
			OpRType:
			begin
				aluControl = instr.r.funct;	// Function field is the ALU code
				regDst = 1'b1;
				regWrite = 1'b1;
			end
			OpAddi, OpAddiu, OpSlti, OpSltiu:
			begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
				signExtend = 1'b1;
				case (instr.i.op)
					OpAddi: aluControl = AluAdd;
					OpAddiu: aluControl = AluAddu;
					OpSlti: aluControl = AluSlt;
					default: aluControl = AluSltu;
				endcase
			end
			OpAndi, OpOri, OpXori:
			begin
				aluSrc = 1'b1;
				regWrite = 1'b1;	// Zero-extended immediate
				case (instr.i.op)
					OpAndi: aluControl = AluAnd;
					OpOri: aluControl = AluOr;
					default: aluControl = AluXor;
				endcase
			end
			OpLui:
			begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
				aluControl = AluLui;
			end
			OpLw:
			begin
				memToReg = 1'b1;
				aluSrc = 1'b1;
				regWrite = 1'b1;
				signExtend = 1'b1;	// Signed offset
				aluControl = AluAdd;
			end
			OpSw:
			begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
				signExtend = 1'b1;
				aluControl = AluAdd;
			end
			OpHalt: halt = 1'b1;	// Writes nothing
			default: regWrite = 1'b0;	// Unknown opcode
		endcase
	end

endmodule

`default_nettype wire

/* hdl/dataMem.sv */
`default_nettype none

module dataMem (
	input  logic clk,
	input  logic rst,
	input  logic [mipsPkg::MemAddrWidth-1:0] addr,
	input  logic [31:0] wdata,
	input  logic we,
	output logic [31:0] rdata
);
	import mipsPkg::*;

	logic [31:0] words [MemWords];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 0; k < MemWords; k++)
				words[k] <= '0;
		end
		else if (we)
			words[addr] <= wdata;
	end

	assign rdata = words[addr];	// Load data same cycle

endmodule

`default_nettype wire

/* hdl/execUnit.sv */
`default_nettype none

module execUnit (
	input  logic clk,
	input  logic rst,
	input  logic issue,
	input  logic memToReg,
	input  logic memWrite,
	input  logic aluSrc,
	input  logic regWrite,
	input  logic [5:0] aluControl,
	input  logic [31:0] imm,	// Already extended
	input  logic [mipsPkg::RegAddrWidth-1:0] destReg,
	input  logic [31:0] rsData,
	input  logic [31:0] rtData,
	input  logic [31:0] memRdata,
	output logic [mipsPkg::MemAddrWidth-1:0] memAddr,
	output logic [31:0] memWdata,
	output logic memWe,
	output logic wrEn,
	output logic [mipsPkg::RegAddrWidth-1:0] wrAddr,
	output logic [31:0] wrData,
	output logic wbValid,
	output logic [mipsPkg::RegAddrWidth-1:0] wbReg,
	output logic [31:0] wbData
);
	import mipsPkg::*;

	logic exMemToReg, exMemWrite, exAluSrc, exRegWrite;
	logic [5:0] exAluControl;
	logic [31:0] exRs, exRt, exImm;
	logic [RegAddrWidth-1:0] exDest;
	logic [31:0] aluB;
	logic [31:0] aluResult;

	//////////////////////////////////////////////////////////////////////
	// Execute stage register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			exMemToReg <= 1'b0;
			exMemWrite <= 1'b0;
			exAluSrc <= 1'b0;
			exRegWrite <= 1'b0;
			exAluControl <= '0;
		end
		else
		begin
			// Idle cycle becomes a bubble with no side effects
			exMemToReg <= issue && memToReg;
			exMemWrite <= issue && memWrite;
			exAluSrc <= aluSrc;
			exRegWrite <= issue && regWrite;
			exAluControl <= aluControl;
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			exRs <= rsData;
			exRt <= rtData;
			exImm <= imm;
			exDest <= destReg;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// ALU and memory access
	//////////////////////////////////////////////////////////////////////
	assign aluB = exAluSrc ? exImm : exRt;

	always_comb
	begin
		case (exAluControl)
			AluAdd, AluAddu: aluResult = exRs + aluB;	// Wraps, no trap
			AluSub: aluResult = exRs - aluB;
			AluAnd: aluResult = exRs & aluB;
			AluOr: aluResult = exRs | aluB;
			AluXor: aluResult = exRs ^ aluB;
			AluSlt: aluResult = {31'b0, $signed(exRs) < $signed(aluB)};
			AluSltu: aluResult = {31'b0, exRs < aluB};
			AluLui: aluResult = {aluB[15:0], 16'b0};
			default: aluResult = '0;
		endcase
	end

	assign memAddr = aluResult[MemAddrWidth+1:2];	// Word index
	assign memWdata = exRt;
	assign memWe = exMemWrite;

	// Write port back into the register file
	assign wrEn = exRegWrite;
	assign wrAddr = exDest;
	assign wrData = exMemToReg ? memRdata : aluResult;

	always_ff @(posedge clk)
	begin
		if (rst)
			wbValid <= 1'b0;
		else
			wbValid <= wrEn && wrAddr != '0;	// r0 writes not reported
	end

	always_ff @(posedge clk)
	begin
		wbReg <= wrAddr;
		wbData <= wrData;
	end

endmodule

`default_nettype wire

/* hdl/instrQueue.sv */
`default_nettype none

module instrQueue (
	input  logic clk,
	input  logic rst,
	input  logic instrValid,
	input  mipsPkg::instrWord instr,
	input  logic pop,
	output logic headValid,
	output mipsPkg::instrWord head,
	output logic creditReturn
);
	import mipsPkg::*;

	instrWord slots [QueueDepth];
	logic [QueuePtrWidth-1:0] wrPtr;
	logic [QueuePtrWidth-1:0] rdPtr;
	logic [CreditWidth-1:0] count;

	function automatic logic [QueuePtrWidth-1:0] nextPtr(input logic [QueuePtrWidth-1:0] ptr);
		return (ptr == QueuePtrWidth'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Sender never writes without a credit, so no full check
	always_ff @(posedge clk)
	begin
		if (instrValid)
			slots[wrPtr] <= instr;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (instrValid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({instrValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
			creditReturn <= pop;	// One credit back per popped word
		end
	end

	assign headValid = (count != '0);
	assign head = slots[rdPtr];

endmodule

`default_nettype wire

/* hdl/mipsCore.sv */
`default_nettype none

module mipsCore (
	input  logic clk,
	input  logic rst,
	input  logic instrValid,
	input  mipsPkg::instrWord instr,
	output logic creditReturn,
	output logic wbValid,
	output logic [mipsPkg::RegAddrWidth-1:0] wbReg,
	output logic [31:0] wbData,
	output logic halted
);
	import mipsPkg::*;

	instrWord head;
	logic headValid, pop;
	logic memToReg, memWrite, aluSrc, regDst, regWrite, signExtend, halt;
	logic [5:0] aluControl;
	logic [31:0] rsData, rtData, imm;
	logic [RegAddrWidth-1:0] destReg;
	logic [MemAddrWidth-1:0] memAddr;
	logic [31:0] memWdata, memRdata;
	logic memWe;
	logic wrEn;
	logic [RegAddrWidth-1:0] wrAddr;
	logic [31:0] wrData;

	//////////////////////////////////////////////////////////////////////
	// Issue and halt
	//////////////////////////////////////////////////////////////////////
	assign pop = headValid && !halted;	// No stall besides halt

	always_ff @(posedge clk)
	begin
		if (rst)
			halted <= 1'b0;
		else if (pop && halt)
			halted <= 1'b1;
	end

	// Immediate extension and destination select
	assign imm = signExtend ? {{16{head.i.imm[15]}}, head.i.imm} : {16'b0, head.i.imm};
	assign destReg = regDst ? head.r.rd : head.i.rt;

	instrQueue instrQueue_i (.*);

	controlUnit controlUnit_i (.instr(head), .*);

	regFile regFile_i (.rsAddr(head.i.rs), .rtAddr(head.i.rt), .*);

	execUnit execUnit_i (.issue(pop), .*);

	dataMem dataMem_i (
		.addr(memAddr),
		.wdata(memWdata),
		.we(memWe),
		.rdata(memRdata),
		.*
	);

endmodule

`default_nettype wire

/* hdl/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////
	localparam int QueueDepth = 4;	// Sender starts with this many credits
	localparam int CreditWidth = 3;	// Holds 0..QueueDepth
	localparam int QueuePtrWidth = $clog2(QueueDepth);
	localparam int RegCount = 32;
	localparam int RegAddrWidth = $clog2(RegCount);
	localparam int MemWords = 16;
	localparam int MemAddrWidth = $clog2(MemWords);	// Word index, bits 5:2 of address

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////
	localparam logic [5:0] OpRType = 6'b000000;
	localparam logic [5:0] OpAddi = 6'b001000;
	localparam logic [5:0] OpAddiu = 6'b001001;
	localparam logic [5:0] OpAndi = 6'b001100;
	localparam logic [5:0] OpOri = 6'b001101;
	localparam logic [5:0] OpXori = 6'b001110;
	localparam logic [5:0] OpSlti = 6'b001010;
	localparam logic [5:0] OpSltiu = 6'b001011;
	localparam logic [5:0] OpLui = 6'b001111;
	localparam logic [5:0] OpLw = 6'b100011;
	localparam logic [5:0] OpSw = 6'b101011;
	localparam logic [5:0] OpHalt = 6'b111111;

	// ALU codes, same values as the R-type function field
	localparam logic [5:0] AluAdd = 6'b100000;
	localparam logic [5:0] AluAddu = 6'b100001;
	localparam logic [5:0] AluSub = 6'b100010;
	localparam logic [5:0] AluAnd = 6'b100100;
	localparam logic [5:0] AluOr = 6'b100101;
	localparam logic [5:0] AluXor = 6'b100110;
	localparam logic [5:0] AluSlt = 6'b101010;
	localparam logic [5:0] AluSltu = 6'b101011;
	localparam logic [5:0] AluLui = 6'b001111;	// No R-type twin

	// Instruction word views
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeFields;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iTypeFields;

	typedef union packed {
		rTypeFields r;
		iTypeFields i;
	} instrWord;

endpackage

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile (
	input  logic clk,
	input  logic rst,
	input  logic [mipsPkg::RegAddrWidth-1:0] rsAddr,
	input  logic [mipsPkg::RegAddrWidth-1:0] rtAddr,
	input  logic wrEn,
	input  logic [mipsPkg::RegAddrWidth-1:0] wrAddr,
	input  logic [31:0] wrData,
	output logic [31:0] rsData,
	output logic [31:0] rtData
);
	import mipsPkg::*;

	logic [31:0] regs [RegCount];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 0; k < RegCount; k++)
				regs[k] <= '0;
		end
		else if (wrEn && wrAddr != '0)	// r0 stays zero
			regs[wrAddr] <= wrData;
	end

	// Same-cycle write bypasses the array
	function automatic logic [31:0] readReg(input logic [RegAddrWidth-1:0] addr);
		if (addr == '0)
			return '0;
		if (wrEn && wrAddr == addr)
			return wrData;
		return regs[addr];
	endfunction

	always_comb
	begin
		rsData = readReg(rsAddr);
		rtData = readReg(rtAddr);
	end

endmodule

`default_nettype wire

/* sources.f */
hdl/mipsPkg.sv
hdl/instrQueue.sv
hdl/controlUnit.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/dataMem.sv
hdl/mipsCore.sv
dv/mipsCoreTb.sv
